/* common/fpu_pkg.sv */
package fpu_pkg;

    // binary32 field widths
    localparam int EXP_W    = 8;
    localparam int MAN_W    = 23;
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = (1 << EXP_W) - 1;            // All-ones exponent marks inf and NaN

    // Raw mantissa from stage 2 is carry, hidden bit, fraction and one guard bit
    localparam int RAW_W = MAN_W + 3;

    localparam logic [31:0] QNAN = 32'h7FC0_0000;           // Canonical quiet NaN

    // Opcode values follow the ALU encoding, the gaps stay reserved
    typedef enum logic [2:0] {
        OP_NOP = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_MUL = 3'd3,
        OP_SLT = 3'd6
    } fp_op_e;

    // Subnormal operands are flushed into CLS_ZERO
    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0,
        CLS_NORMAL = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } fp_class_e;

    // Result tag carried from stage 2 to stage 3
    typedef enum logic [1:0] {
        KIND_NUM  = 2'd0,                                   // Raw mantissa still needs normalizing
        KIND_WORD = 2'd1,                                   // Finished 32-bit word
        KIND_INF  = 2'd2,                                   // Signed infinity
        KIND_INV  = 2'd3                                    // Invalid operation
    } fp_kind_e;

endpackage

/* fpu/fpu_unpack.sv */
`timescale 1ns/1ps

module fpu_unpack (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  fpu_pkg::fp_op_e             in_op,
    input  logic [31:0]                 in_a,
    input  logic [31:0]                 in_b,
    output logic                        in_ready,
    output logic                        s1_valid,
    input  logic                        s1_ready,
    output fpu_pkg::fp_op_e             s1_op,
    output logic                        sign_a,
    output logic                        sign_b,
    output logic [fpu_pkg::EXP_W-1:0]   exp_a,
    output logic [fpu_pkg::EXP_W-1:0]   exp_b,
    output logic [fpu_pkg::MAN_W:0]     man_a,
    output logic [fpu_pkg::MAN_W:0]     man_b,
    output fpu_pkg::fp_class_e          cls_a,
    output fpu_pkg::fp_class_e          cls_b
);

    function automatic fpu_pkg::fp_class_e classify(
        input logic [fpu_pkg::EXP_W-1:0] e,
        input logic [fpu_pkg::MAN_W-1:0] f
    );
        fpu_pkg::fp_class_e c;
        if (e == '0) begin
            c = fpu_pkg::CLS_ZERO;                          // Subnormals count as zero
        end else if (e == fpu_pkg::EXP_MAX) begin
            c = (f == '0) ? fpu_pkg::CLS_INF : fpu_pkg::CLS_NAN;
        end else begin
            c = fpu_pkg::CLS_NORMAL;
        end
        return c;
    endfunction

    logic take;

    assign in_ready = !s1_valid || s1_ready;
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (in_ready) begin
            s1_valid <= in_valid;
        end
    end

    // Hidden bit is restored only for nonzero exponents so NOP can rebuild a exactly
    always_ff @(posedge clk) begin
        if (take) begin
            s1_op  <= in_op;
            sign_a <= in_a[31];
            sign_b <= in_b[31];
            exp_a  <= in_a[30:23];
            exp_b  <= in_b[30:23];
            man_a  <= {|in_a[30:23], in_a[22:0]};
            man_b  <= {|in_b[30:23], in_b[22:0]};
            cls_a  <= classify(in_a[30:23], in_a[22:0]);
            cls_b  <= classify(in_b[30:23], in_b[22:0]);
        end
    end

    // An offered input item must stay put until it is taken
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !in_ready) |=> (in_valid && $stable({in_op, in_a, in_b})));

endmodule

/* fpu/fpu_arith.sv */
`timescale 1ns/1ps

module fpu_arith (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          s1_valid,
    output logic                          s1_ready,
    input  fpu_pkg::fp_op_e               s1_op,
    input  logic                          sign_a,
    input  logic                          sign_b,
    input  logic [fpu_pkg::EXP_W-1:0]     exp_a,
    input  logic [fpu_pkg::EXP_W-1:0]     exp_b,
    input  logic [fpu_pkg::MAN_W:0]       man_a,
    input  logic [fpu_pkg::MAN_W:0]       man_b,
    input  fpu_pkg::fp_class_e            cls_a,
    input  fpu_pkg::fp_class_e            cls_b,
    output logic                          s2_valid,
    input  logic                          s2_ready,
    output logic                          s2_sign,
    output logic signed [9:0]             s2_exp,
    output logic [fpu_pkg::RAW_W-1:0]     s2_raw,
    output fpu_pkg::fp_kind_e             s2_kind,
    output logic [31:0]                   s2_word
);

    logic [fpu_pkg::EXP_W-1:0]           ea, eb;
    logic [fpu_pkg::MAN_W:0]             ma, mb;
    logic                                sign_b_eff;
    logic                                a_big;
    logic [fpu_pkg::EXP_W-1:0]           big_exp, exp_diff;
    logic [fpu_pkg::MAN_W:0]             big_man, small_man;
    logic                                big_sign;
    logic [fpu_pkg::RAW_W-1:0]           big_ext, small_ext, add_raw, sub_raw;
    logic [2*fpu_pkg::MAN_W+1:0]         prod;
    logic                                slt_sa, slt_sb, slt_lt;
    logic                                any_nan, any_inf, any_zero;
    logic                                n_sign;
    logic signed [9:0]                   n_exp;
    logic [fpu_pkg::RAW_W-1:0]           n_raw;
    fpu_pkg::fp_kind_e                   n_kind;
    logic [31:0]                         n_word;

    always_comb begin
        ea = (cls_a == fpu_pkg::CLS_ZERO) ? '0 : exp_a;     // Flushed operands become true zeros
        eb = (cls_b == fpu_pkg::CLS_ZERO) ? '0 : exp_b;
        ma = (cls_a == fpu_pkg::CLS_ZERO) ? '0 : man_a;
        mb = (cls_b == fpu_pkg::CLS_ZERO) ? '0 : man_b;
        sign_b_eff = (s1_op == fpu_pkg::OP_SUB) ? ~sign_b : sign_b;

        a_big     = {ea, ma} >= {eb, mb};
        big_exp   = a_big ? ea : eb;
        exp_diff  = a_big ? ea - eb : eb - ea;
        big_man   = a_big ? ma : mb;
        small_man = a_big ? mb : ma;
        big_sign  = a_big ? sign_a : sign_b_eff;
        big_ext   = {1'b0, big_man, 1'b0};
        small_ext = {1'b0, small_man, 1'b0} >> exp_diff;  // Bits past the guard are truncated
        add_raw   = big_ext + small_ext;
        sub_raw   = big_ext - small_ext;

        prod = ma * mb;

        // Zero compares as positive so that +0 and -0 are equal
        slt_sa = sign_a && (cls_a != fpu_pkg::CLS_ZERO);
        slt_sb = sign_b && (cls_b != fpu_pkg::CLS_ZERO);
        if (slt_sa != slt_sb) begin
            slt_lt = slt_sa;
        end else if (!slt_sa) begin
            slt_lt = {ea, ma} < {eb, mb};
        end else begin
            slt_lt = {ea, ma} > {eb, mb};
        end

        any_nan  = (cls_a == fpu_pkg::CLS_NAN) || (cls_b == fpu_pkg::CLS_NAN);
        any_inf  = (cls_a == fpu_pkg::CLS_INF) || (cls_b == fpu_pkg::CLS_INF);
        any_zero = (cls_a == fpu_pkg::CLS_ZERO) || (cls_b == fpu_pkg::CLS_ZERO);

        n_sign = 1'b0;
        n_exp  = '0;
        n_raw  = '0;
        n_kind = fpu_pkg::KIND_WORD;
        n_word = '0;

        case (s1_op)
            fpu_pkg::OP_ADD, fpu_pkg::OP_SUB: begin
                n_exp = {2'b00, big_exp};
                if (any_nan) begin
                    n_kind = fpu_pkg::KIND_INV;
                end else if (cls_a == fpu_pkg::CLS_INF && cls_b == fpu_pkg::CLS_INF) begin
                    n_kind = (sign_a != sign_b_eff) ? fpu_pkg::KIND_INV : fpu_pkg::KIND_INF;
                    n_sign = sign_a;
                end else if (any_inf) begin
                    n_kind = fpu_pkg::KIND_INF;
                    n_sign = (cls_a == fpu_pkg::CLS_INF) ? sign_a : sign_b_eff;
                end else if (cls_a == fpu_pkg::CLS_ZERO && cls_b == fpu_pkg::CLS_ZERO) begin
                    n_word = {sign_a & sign_b_eff, 31'b0};
                end else if (sign_a == sign_b_eff) begin
                    n_kind = fpu_pkg::KIND_NUM;
                    n_sign = big_sign;
                    n_raw  = add_raw;
                end else if (sub_raw != '0) begin
                    n_kind = fpu_pkg::KIND_NUM;
                    n_sign = big_sign;
                    n_raw  = sub_raw;
                end                                         // Exact cancellation leaves +0
            end
            fpu_pkg::OP_MUL: begin
                n_sign = sign_a ^ sign_b;
                n_exp  = {2'b00, ea} + {2'b00, eb} - 10'(fpu_pkg::EXP_BIAS);
                if (any_nan || (any_inf && any_zero)) begin
                    n_kind = fpu_pkg::KIND_INV;
                end else if (any_inf) begin
                    n_kind = fpu_pkg::KIND_INF;
                end else if (any_zero) begin
                    n_word = {sign_a ^ sign_b, 31'b0};
                end else begin
                    n_kind = fpu_pkg::KIND_NUM;
                    n_raw  = prod[2*fpu_pkg::MAN_W+1 -: fpu_pkg::RAW_W];
                end
            end
            fpu_pkg::OP_SLT: begin
                if (any_nan) begin
                    n_kind = fpu_pkg::KIND_INV;
                end else begin
                    n_word = {31'b0, slt_lt};
                end
            end
            default: begin
                n_word = {sign_a, exp_a, man_a[fpu_pkg::MAN_W-1:0]};  // NOP and reserved codes
            end
        endcase
    end

    assign s1_ready = !s2_valid || s2_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else if (s1_ready) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid && s1_ready) begin
            s2_sign <= n_sign;
            s2_exp  <= n_exp;
            s2_raw  <= n_raw;
            s2_kind <= n_kind;
            s2_word <= n_word;
        end
    end

    nan_never_numeric: assert property (@(posedge clk) disable iff (!rst_n)
        (s1_valid && s1_ready && (cls_a == fpu_pkg::CLS_NAN || cls_b == fpu_pkg::CLS_NAN))
        |=> (s2_kind != fpu_pkg::KIND_NUM));

endmodule

/* fpu/fpu_pack.sv */
`timescale 1ns/1ps

module fpu_pack (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        s2_valid,
    output logic                        s2_ready,
    input  logic                        s2_sign,
    input  logic signed [9:0]           s2_exp,
    input  logic [fpu_pkg::RAW_W-1:0]   s2_raw,
    input  fpu_pkg::fp_kind_e           s2_kind,
    input  logic [31:0]                 s2_word,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [31:0]                 out_result,
    output logic                        out_invalid,
    output logic                        out_overflow,
    output logic                        out_underflow
);

    logic [4:0]                  lz_cnt;
    logic [fpu_pkg::RAW_W-1:0]   norm_raw;
    logic signed [9:0]           norm_exp;
    logic [31:0]                 n_result;
    logic                        n_inv, n_ovf, n_unf;

    // Priority search below the carry bit, the highest set bit wins
    always_comb begin
        lz_cnt = 5'(fpu_pkg::RAW_W - 1);
        for (int i = 0; i < fpu_pkg::RAW_W - 1; i++) begin
            if (s2_raw[i]) begin
                lz_cnt = 5'(fpu_pkg::RAW_W - 2 - i);
            end
        end
    end

    always_comb begin
        if (s2_raw[fpu_pkg::RAW_W-1]) begin
            norm_raw = s2_raw >> 1;                         // Carry out of the hidden bit
            norm_exp = s2_exp + 10'sd1;
        end else begin
            norm_raw = s2_raw << lz_cnt;
            norm_exp = s2_exp - $signed({5'b0, lz_cnt});
        end

        n_result = s2_word;
        n_inv    = 1'b0;
        n_ovf    = 1'b0;
        n_unf    = 1'b0;

        case (s2_kind)
            fpu_pkg::KIND_NUM: begin
                if (norm_exp >= fpu_pkg::EXP_MAX) begin
                    n_result = {s2_sign, {fpu_pkg::EXP_W{1'b1}}, {fpu_pkg::MAN_W{1'b0}}};
                    n_ovf    = 1'b1;
                end else if (norm_exp <= 0) begin
                    n_result = {s2_sign, 31'b0};            // Flush to signed zero
                    n_unf    = 1'b1;
                end else begin
                    // Guard bit is dropped here, which truncates toward zero
                    n_result = {s2_sign, norm_exp[fpu_pkg::EXP_W-1:0],
                                norm_raw[fpu_pkg::RAW_W-3:1]};
                end
            end
            fpu_pkg::KIND_INF: begin
                n_result = {s2_sign, {fpu_pkg::EXP_W{1'b1}}, {fpu_pkg::MAN_W{1'b0}}};
            end
            fpu_pkg::KIND_INV: begin
                n_result = fpu_pkg::QNAN;
                n_inv    = 1'b1;
            end
            default: begin
                n_result = s2_word;
            end
        endcase
    end

    assign s2_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (s2_ready) begin
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid && s2_ready) begin
            out_result    <= n_result;
            out_invalid   <= n_inv;
            out_overflow  <= n_ovf;
            out_underflow <= n_unf;
        end
    end

    // Stage 2 must never tag an all-zero mantissa as numeric
    hidden_bit_set: assert property (@(posedge clk) disable iff (!rst_n)
        (s2_valid && s2_kind == fpu_pkg::KIND_NUM) |-> norm_raw[fpu_pkg::RAW_W-2]);

endmodule

/* logic/fpu_top.sv */
`timescale 1ns/1ps

module fpu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  fpu_pkg::fp_op_e     in_op,
    input  logic [31:0]         in_a,
    input  logic [31:0]         in_b,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [31:0]         out_result,
    output logic                out_invalid,
    output logic                out_overflow,
    output logic                out_underflow
);

    logic                              s1_valid;
    logic                              s1_ready;
    fpu_pkg::fp_op_e                   s1_op;
    logic                              sign_a, sign_b;
    logic [fpu_pkg::EXP_W-1:0]         exp_a, exp_b;
    logic [fpu_pkg::MAN_W:0]           man_a, man_b;
    fpu_pkg::fp_class_e                cls_a, cls_b;

    logic                              s2_valid;
    logic                              s2_ready;
    logic                              s2_sign;
    logic signed [9:0]                 s2_exp;
    logic [fpu_pkg::RAW_W-1:0]         s2_raw;
    fpu_pkg::fp_kind_e                 s2_kind;
    logic [31:0]                       s2_word;

    fpu_unpack fpu_unpack_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_ready (in_ready),
        .s1_valid (s1_valid),
        .s1_ready (s1_ready),
        .s1_op    (s1_op),
        .sign_a   (sign_a),
        .sign_b   (sign_b),
        .exp_a    (exp_a),
        .exp_b    (exp_b),
        .man_a    (man_a),
        .man_b    (man_b),
        .cls_a    (cls_a),
        .cls_b    (cls_b)
    );

    fpu_arith fpu_arith_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .s1_valid (s1_valid),
        .s1_ready (s1_ready),
        .s1_op    (s1_op),
        .sign_a   (sign_a),
        .sign_b   (sign_b),
        .exp_a    (exp_a),
        .exp_b    (exp_b),
        .man_a    (man_a),
        .man_b    (man_b),
        .cls_a    (cls_a),
        .cls_b    (cls_b),
        .s2_valid (s2_valid),
        .s2_ready (s2_ready),
        .s2_sign  (s2_sign),
        .s2_exp   (s2_exp),
        .s2_raw   (s2_raw),
        .s2_kind  (s2_kind),
        .s2_word  (s2_word)
    );

    fpu_pack fpu_pack_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .s2_valid      (s2_valid),
        .s2_ready      (s2_ready),
        .s2_sign       (s2_sign),
        .s2_exp        (s2_exp),
        .s2_raw        (s2_raw),
        .s2_kind       (s2_kind),
        .s2_word       (s2_word),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_result    (out_result),
        .out_invalid   (out_invalid),
        .out_overflow  (out_overflow),
        .out_underflow (out_underflow)
    );

endmodule

/* bench/fpu_clock.sv */
`timescale 1ns/1ps

module fpu_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                              // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* bench/fpu_tb.sv */
`timescale 1ns/1ps

module fpu_tb;

    localparam int  MAX_CASES  = 96;
    localparam int  RAND_CASES = 40;
    localparam time LATENCY_NS = 12;                        // Three stages at the 4 ns clock

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic            in_ready;
    fpu_pkg::fp_op_e in_op;
    logic [31:0]     in_a;
    logic [31:0]     in_b;
    logic            out_valid;
    logic            out_ready;
    logic [31:0]     out_result;
    logic            out_invalid;
    logic            out_overflow;
    logic            out_underflow;

    string           case_name  [MAX_CASES];
    fpu_pkg::fp_op_e case_op    [MAX_CASES];
    logic [31:0]     case_a     [MAX_CASES];
    logic [31:0]     case_b     [MAX_CASES];
    logic [31:0]     case_res   [MAX_CASES];
    logic [2:0]      case_flags [MAX_CASES];                // Invalid, overflow, underflow
    time             sent_at    [MAX_CASES];

    int          n_cases;
    int          n_fixed;
    int          received;
    int          mismatches;
    int          other_errors;
    logic [31:0] lfsr;
    time         last_stall;

    fpu_clock fpu_clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fpu_top fpu_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_op         (in_op),
        .in_a          (in_a),
        .in_b          (in_b),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_result    (out_result),
        .out_invalid   (out_invalid),
        .out_overflow  (out_overflow),
        .out_underflow (out_underflow)
    );

    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
    endfunction

    function automatic void add_case(input string name, input fpu_pkg::fp_op_e op,
                                     input logic [31:0] a, input logic [31:0] b,
                                     input logic [31:0] res, input logic [2:0] flags);
        case_name[n_cases]  = name;
        case_op[n_cases]    = op;
        case_a[n_cases]     = a;
        case_b[n_cases]     = b;
        case_res[n_cases]   = res;
        case_flags[n_cases] = flags;
        n_cases++;
    endfunction

    // Sign first, then exponent and fraction, with any zero counted as +0
    function automatic void add_random_slt(input int idx);
        logic [31:0] a;
        logic [31:0] b;
        logic        za, zb, na, nb, lt;
        a = draw_bits(32);
        b = draw_bits(32);
        if (next_bit()) begin
            b[30:23] = a[30:23];                            // Same exponent so the fraction decides
        end
        za = (a[30:23] == 8'h00);
        zb = (b[30:23] == 8'h00);
        na = a[31] && !za;
        nb = b[31] && !zb;
        if (na != nb) begin
            lt = na;
        end else if (!na) begin
            lt = (za ? 31'd0 : a[30:0]) < (zb ? 31'd0 : b[30:0]);
        end else begin
            lt = a[30:0] > b[30:0];
        end
        if (is_nan(a) || is_nan(b)) begin
            add_case($sformatf("slt_rand_%0d", idx), fpu_pkg::OP_SLT, a, b, 32'h7FC00000, 3'b100);
        end else begin
            add_case($sformatf("slt_rand_%0d", idx), fpu_pkg::OP_SLT, a, b, {31'd0, lt}, 3'b000);
        end
    endfunction

    function automatic void load_table();
        lfsr    = 32'd72435;
        n_cases = 0;
        add_case("add_exact", fpu_pkg::OP_ADD, 32'h3FC00000, 32'h40100000, 32'h40700000, 3'b000);
        add_case("add_carry", fpu_pkg::OP_ADD, 32'h3F800000, 32'h3F800000, 32'h40000000, 3'b000);
        add_case("add_neg", fpu_pkg::OP_ADD, 32'hBFC00000, 32'hC0100000, 32'hC0700000, 3'b000);
        add_case("add_opp", fpu_pkg::OP_ADD, 32'h40A00000, 32'hC0E00000, 32'hC0000000, 3'b000);
        add_case("add_nzero", fpu_pkg::OP_ADD, 32'h80000000, 32'h80000000, 32'h80000000, 3'b000);
        add_case("add_trunc", fpu_pkg::OP_ADD, 32'h4B800000, 32'h3F800000, 32'h4B800000, 3'b000);
        add_case("sub_neg", fpu_pkg::OP_SUB, 32'h40A00000, 32'h40E00000, 32'hC0000000, 3'b000);
        add_case("sub_cancel", fpu_pkg::OP_SUB, 32'h40400000, 32'h40400000, 32'h00000000, 3'b000);
        add_case("sub_shift", fpu_pkg::OP_SUB, 32'h3F800000, 32'h3F400000, 32'h3E800000, 3'b000);
        add_case("mul_exact", fpu_pkg::OP_MUL, 32'h3FC00000, 32'h40000000, 32'h40400000, 3'b000);
        add_case("mul_sign", fpu_pkg::OP_MUL, 32'hC0400000, 32'h40200000, 32'hC0F00000, 3'b000);
        add_case("mul_carry", fpu_pkg::OP_MUL, 32'h3FC00000, 32'h3FC00000, 32'h40100000, 3'b000);
        add_case("mul_negneg", fpu_pkg::OP_MUL, 32'hBF800000, 32'hC0000000, 32'h40000000, 3'b000);
        add_case("mul_ovf", fpu_pkg::OP_MUL, 32'h71800000, 32'h71800000, 32'h7F800000, 3'b010);
        add_case("mul_unf", fpu_pkg::OP_MUL, 32'h0D800000, 32'h0D800000, 32'h00000000, 3'b001);
        add_case("nan_add", fpu_pkg::OP_ADD, 32'h7F800001, 32'h3F800000, 32'h7FC00000, 3'b100);
        add_case("nan_mul", fpu_pkg::OP_MUL, 32'h3F800000, 32'hFFC00000, 32'h7FC00000, 3'b100);
        add_case("inf_sub_inf", fpu_pkg::OP_SUB, 32'h7F800000, 32'h7F800000, 32'h7FC00000, 3'b100);
        add_case("zero_mul_inf", fpu_pkg::OP_MUL, 32'h0, 32'h7F800000, 32'h7FC00000, 3'b100);
        add_case("inf_add", fpu_pkg::OP_ADD, 32'h7F800000, 32'h40A00000, 32'h7F800000, 3'b000);
        add_case("inf_add_inf", fpu_pkg::OP_ADD, 32'h7F800000, 32'h7F800000, 32'h7F800000, 3'b000);
        add_case("ninf_mul", fpu_pkg::OP_MUL, 32'hFF800000, 32'hC0000000, 32'h7F800000, 3'b000);
        add_case("subn_add", fpu_pkg::OP_ADD, 32'h00000001, 32'h40000000, 32'h40000000, 3'b000);
        add_case("subn_mul", fpu_pkg::OP_MUL, 32'h80000010, 32'h40400000, 32'h80000000, 3'b000);
        add_case("slt_lt", fpu_pkg::OP_SLT, 32'h3F800000, 32'h40000000, 32'h00000001, 3'b000);
        add_case("slt_gt", fpu_pkg::OP_SLT, 32'h40000000, 32'h3F800000, 32'h00000000, 3'b000);
        add_case("slt_eq", fpu_pkg::OP_SLT, 32'h3F800000, 32'h3F800000, 32'h00000000, 3'b000);
        add_case("slt_negpos", fpu_pkg::OP_SLT, 32'hBF800000, 32'h3F800000, 32'h00000001, 3'b000);
        add_case("slt_negneg", fpu_pkg::OP_SLT, 32'hC0000000, 32'hBF800000, 32'h00000001, 3'b000);
        add_case("slt_frac", fpu_pkg::OP_SLT, 32'h3F800001, 32'h3F800002, 32'h00000001, 3'b000);
        add_case("slt_pz_nz", fpu_pkg::OP_SLT, 32'h00000000, 32'h80000000, 32'h00000000, 3'b000);
        add_case("slt_nz_pz", fpu_pkg::OP_SLT, 32'h80000000, 32'h00000000, 32'h00000000, 3'b000);
        add_case("slt_nan", fpu_pkg::OP_SLT, 32'h7FC00000, 32'h3F800000, 32'h7FC00000, 3'b100);
        add_case("nop_word", fpu_pkg::OP_NOP, 32'h12345678, 32'h9ABCDEF0, 32'h12345678, 3'b000);
        add_case("nop_neg", fpu_pkg::OP_NOP, 32'hC0490FDB, 32'h00000000, 32'hC0490FDB, 3'b000);
        n_fixed = n_cases;
        for (int i = 0; i < RAND_CASES; i++) begin
            add_random_slt(i);
        end
    endfunction

    function automatic void compare_field(input string test, input string field,
                                          input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %08h, actual %08h", test, field, expected, actual);
            mismatches++;
        end
    endfunction

    task automatic finish_run();
        $display("results %0d of %0d, mismatches %0d, other errors %0d",
                 received, n_cases, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // Driver keeps in_valid high between items so the stream runs back to back
    initial begin
        logic accepted;
        in_valid = 1'b0;
        in_op    = fpu_pkg::OP_NOP;
        in_a     = '0;
        in_b     = '0;
        load_table();
        wait (rst_n === 1'b1);
        for (int i = 0; i < n_cases; i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_op    = case_op[i];
            in_a     = case_a[i];
            in_b     = case_b[i];
            accepted = 1'b0;
            while (!accepted) begin
                #1;
                accepted = in_ready;
                @(posedge clk);
                if (!accepted) begin
                    @(negedge clk);
                end
            end
            sent_at[i] = $time;
        end
        @(negedge clk);
        in_valid = 1'b0;
    end

    initial begin
        logic        moving;
        logic        stall_on;
        logic [31:0] got_res;
        logic [2:0]  got_flags;
        out_ready    = 1'b0;
        last_stall   = 0;
        received     = 0;
        mismatches   = 0;
        other_errors = 0;
        wait (rst_n === 1'b1);
        #1;
        if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
            $display("after reset in_ready is not high or out_valid is not low");
            other_errors++;
        end
        while (received < n_cases) begin
            @(negedge clk);
            stall_on  = (received >= n_fixed) && (draw_bits(2) == 32'd0);  // Stalls in random part
            out_ready = !stall_on;
            #1;
            moving    = out_valid && out_ready;
            got_res   = out_result;
            got_flags = {out_invalid, out_overflow, out_underflow};
            @(posedge clk);
            if (stall_on) begin
                last_stall = $time;
            end
            if (moving) begin
                compare_field(case_name[received], "result", case_res[received], got_res);
                compare_field(case_name[received], "invalid", 32'(case_flags[received][2]),
                              32'(got_flags[2]));
                compare_field(case_name[received], "overflow", 32'(case_flags[received][1]),
                              32'(got_flags[1]));
                compare_field(case_name[received], "underflow", 32'(case_flags[received][0]),
                              32'(got_flags[0]));
                if (last_stall <= sent_at[received]) begin
                    compare_field(case_name[received], "latency ns", 32'(LATENCY_NS),
                                  32'($time - sent_at[received]));
                end
                received++;
            end
        end
        repeat (10) begin
            @(negedge clk);
            out_ready = 1'b1;
            #1;
            if (out_valid === 1'b1) begin
                $display("extra output %08h after all %0d results", out_result, n_cases);
                other_errors++;
            end
        end
        finish_run();
    end

    initial begin
        wait (rst_n === 1'b1);
        repeat (n_cases * 20) @(posedge clk);
        $display("watchdog expired with %0d of %0d results received", received, n_cases);
        other_errors++;
        finish_run();
    end

endmodule

/* list.f */
common/fpu_pkg.sv
fpu/fpu_unpack.sv
fpu/fpu_arith.sv
fpu/fpu_pack.sv
logic/fpu_top.sv
bench/fpu_clock.sv
bench/fpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fpu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
